// ==== hw/xbar_pkg.sv ====
// Fixed memory map: two 1 KiB banks from address 0, anything at 2 KiB and above is unmapped.
package xbar_pkg;

    // Byte address width.
    localparam int ALEN = 16;
    // Data width.
    localparam int DLEN = 32;
    // One write enable per byte.
    localparam int WES = DLEN / 8;

    // CPU-side request ports.
    localparam int N_CPUS = 2;
    // SRAM banks.
    localparam int N_BANKS = 2;

    // Word address bits inside one bank, 256 words.
    localparam int BANK_AW = 8;
    // First address bit of the bank index.
    localparam int BANK_SEL_LSB = 10;
    // Address bits from here up must be zero for a mapped access.
    localparam int MAP_TOP_LSB = 11;

    // Width of a bank index.
    localparam int BANK_IDX_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
    // Width of a CPU index.
    localparam int CPU_IDX_W = (N_CPUS > 1) ? $clog2(N_CPUS) : 1;

endpackage

// ==== hw/mem_bus_if.sv ====
// Ready in the cycle after a request means it was done; read data is valid in that cycle.
interface mem_bus_if;
    import xbar_pkg::*;

    // Read enable.
    logic             re;
    // Byte write enables.
    logic [WES-1:0]   we;
    // Word address.
    logic [ALEN-1:2]  addr;
    // Write data.
    logic [DLEN-1:0]  wdata;
    // Previous request was performed.
    logic             ready;
    // Read data, valid with ready.
    logic [DLEN-1:0]  rdata;

    // Requesting side.
    modport master (output re, we, addr, wdata, input ready, rdata);
    // Responding side.
    modport slave (output ready, rdata, input re, we, addr, wdata);

endinterface

// ==== hw/addr_decoder.sv ====
// Memory map is fixed by the package; unmapped requests reach no lane and leave sel_q at zero.
module addr_decoder (
    input  logic                          clk,
    input  logic                          rst,
    mem_bus_if.slave                      cpu,
    mem_bus_if.master                     lane [xbar_pkg::N_BANKS],
    output logic [xbar_pkg::N_BANKS-1:0]  sel_q
);
    import xbar_pkg::*;

    // Any access this cycle.
    logic                   req;
    // Address falls inside one of the banks.
    logic                   mapped;
    // Bank index taken from the address.
    logic [BANK_IDX_W-1:0]  bank_idx;
    // One-hot lane select for the current request.
    logic [N_BANKS-1:0]     sel;

    assign req      = cpu.re || (|cpu.we);
    // All bits above the bank index must be clear.
    assign mapped   = (cpu.addr[ALEN-1:MAP_TOP_LSB] == '0);
    assign bank_idx = cpu.addr[BANK_SEL_LSB +: BANK_IDX_W];

    // Steer the strobes, share address and data.
    genvar b;
    generate
        for (b = 0; b < N_BANKS; b = b + 1) begin : g_lane
            assign sel[b]        = mapped && (bank_idx == BANK_IDX_W'(b));
            assign lane[b].re    = sel[b] && cpu.re;
            assign lane[b].we    = sel[b] ? cpu.we : '0;
            // Every bank sees the address; only the selected one gets strobes.
            assign lane[b].addr  = cpu.addr;
            assign lane[b].wdata = cpu.wdata;
        end
    endgenerate

    // Remember where the request went.
    // Zero here means idle or unmapped, answered with ready by the router.
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (req) begin
            sel_q <= sel;
        end else begin
            sel_q <= '0;
        end
    end

endmodule

// ==== hw/bank_arbiter.sv ====
// Round-robin over the CPU lanes, one access per cycle; the bank must answer reads in one cycle.
module bank_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    mem_bus_if.slave                      lane [xbar_pkg::N_CPUS],
    output logic                          mem_re,
    output logic [xbar_pkg::WES-1:0]      mem_we,
    output logic [xbar_pkg::BANK_AW-1:0]  mem_addr,
    output logic [xbar_pkg::DLEN-1:0]     mem_wdata,
    input  logic [xbar_pkg::DLEN-1:0]     mem_rdata
);
    import xbar_pkg::*;

    // Lane requests gathered into arrays.
    logic [N_CPUS-1:0]     req;
    logic [N_CPUS-1:0]     lane_re;
    logic [WES-1:0]        lane_we    [N_CPUS];
    logic [BANK_AW-1:0]    lane_addr  [N_CPUS];
    logic [DLEN-1:0]       lane_wdata [N_CPUS];

    // Grant for this cycle, one-hot.
    logic [N_CPUS-1:0]     grant;
    // Index of the granted CPU.
    logic [CPU_IDX_W-1:0]  grant_idx;
    // Grant of the previous cycle, drives ready.
    logic [N_CPUS-1:0]     grant_q;
    // Last CPU served.
    logic [CPU_IDX_W-1:0]  last_q;

    genvar c;
    generate
        for (c = 0; c < N_CPUS; c = c + 1) begin : g_lane
            assign lane_re[c]    = lane[c].re;
            assign lane_we[c]    = lane[c].we;
            // Only the in-bank word offset reaches the SRAM.
            assign lane_addr[c]  = lane[c].addr[BANK_SEL_LSB-1:2];
            assign lane_wdata[c] = lane[c].wdata;
            assign req[c]        = lane[c].re || (|lane[c].we);
            // Ready one cycle after the grant.
            assign lane[c].ready = grant_q[c];
            // Only the ready lane's data is taken.
            assign lane[c].rdata = mem_rdata;
        end
    endgenerate

    // Search starts just after the last served CPU.
    always_comb begin
        int  idx;
        logic found;
        grant     = '0;
        grant_idx = last_q;
        found     = 1'b0;
        for (int i = 1; i <= N_CPUS; i++) begin
            idx = (int'(last_q) + i) % N_CPUS;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = CPU_IDX_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // One-hot multiplexer onto the bank.
    always_comb begin
        mem_re    = 1'b0;
        mem_we    = '0;
        mem_addr  = '0;
        mem_wdata = '0;
        for (int i = 0; i < N_CPUS; i++) begin
            if (grant[i]) begin
                mem_re    |= lane_re[i];
                mem_we    |= lane_we[i];
                mem_addr  |= lane_addr[i];
                mem_wdata |= lane_wdata[i];
            end
        end
    end

    // After reset CPU 0 is searched first.
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= '0;
            last_q  <= CPU_IDX_W'(N_CPUS - 1);
        end else begin
            grant_q <= grant;
            if (|grant) begin
                last_q <= grant_idx;
            end
        end
    end

endmodule

// ==== hw/resp_router.sv ====
// Combinational; sel_q of zero means idle or unmapped and returns ready with zero read data.
module resp_router (
    input  logic [xbar_pkg::N_BANKS-1:0]  sel_q,
    mem_bus_if.slave                      lane [xbar_pkg::N_BANKS],
    mem_bus_if.slave                      cpu
);
    import xbar_pkg::*;

    // Responses of every lane.
    logic [N_BANKS-1:0]  lane_ready;
    logic [DLEN-1:0]     lane_rdata [N_BANKS];

    genvar b;
    generate
        for (b = 0; b < N_BANKS; b = b + 1) begin : g_lane
            assign lane_ready[b] = lane[b].ready;
            assign lane_rdata[b] = lane[b].rdata;
        end
    endgenerate

    // Pick the lane that the last request used.
    always_comb begin
        // Nothing outstanding, so nothing to wait for.
        cpu.ready = (sel_q == '0);
        cpu.rdata = '0;
        for (int i = 0; i < N_BANKS; i++) begin
            if (sel_q[i]) begin
                cpu.ready |= lane_ready[i];
                cpu.rdata |= lane_rdata[i];
            end
        end
    end

endmodule

// ==== hw/sram_bank.sv ====
// Contents are not cleared; a read of a word written in the same cycle returns the old data.
module sram_bank (
    input  logic                          clk,
    input  logic                          re,
    input  logic [xbar_pkg::WES-1:0]      we,
    input  logic [xbar_pkg::BANK_AW-1:0]  addr,
    input  logic [xbar_pkg::DLEN-1:0]     wdata,
    output logic [xbar_pkg::DLEN-1:0]     rdata
);
    import xbar_pkg::*;

    // Word array.
    logic [DLEN-1:0] mem [2**BANK_AW];

    // Byte-wise writes.
    always_ff @(posedge clk) begin
        for (int i = 0; i < WES; i++) begin
            if (we[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Registered read, held while idle.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hw/xbar_top.sv ====
// Two CPUs to two banks; one access in flight per CPU, unmapped accesses complete with no effect.
module xbar_top (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [xbar_pkg::N_CPUS-1:0]                  cpu_re,
    input  logic [xbar_pkg::N_CPUS-1:0][xbar_pkg::WES-1:0]   cpu_we,
    input  logic [xbar_pkg::N_CPUS-1:0][xbar_pkg::ALEN-1:2]  cpu_addr,
    input  logic [xbar_pkg::N_CPUS-1:0][xbar_pkg::DLEN-1:0]  cpu_wdata,
    output logic [xbar_pkg::N_CPUS-1:0]                  cpu_ready,
    output logic [xbar_pkg::N_CPUS-1:0][xbar_pkg::DLEN-1:0]  cpu_rdata
);
    import xbar_pkg::*;

    genvar c, b;
    generate
        // CPU side: decode and response routing.
        for (c = 0; c < N_CPUS; c = c + 1) begin : g_cpu
            mem_bus_if          cpu_if ();
            mem_bus_if          lane_if [N_BANKS] ();
            logic [N_BANKS-1:0] sel_q;

            assign cpu_if.re     = cpu_re[c];
            assign cpu_if.we     = cpu_we[c];
            assign cpu_if.addr   = cpu_addr[c];
            assign cpu_if.wdata  = cpu_wdata[c];
            assign cpu_ready[c]  = cpu_if.ready;
            assign cpu_rdata[c]  = cpu_if.rdata;

            addr_decoder u_dec (.clk(clk), .rst(rst), .cpu(cpu_if), .lane(lane_if),
                                .sel_q(sel_q));
            resp_router u_rtr (.sel_q(sel_q), .lane(lane_if), .cpu(cpu_if));
        end

        // Bank side: arbitration and storage.
        for (b = 0; b < N_BANKS; b = b + 1) begin : g_bank
            mem_bus_if          port_if [N_CPUS] ();
            logic               mem_re;
            logic [WES-1:0]     mem_we;
            logic [BANK_AW-1:0] mem_addr;
            logic [DLEN-1:0]    mem_wdata;
            logic [DLEN-1:0]    mem_rdata;

            bank_arbiter u_arb (.clk(clk), .rst(rst), .lane(port_if), .mem_re(mem_re),
                                .mem_we(mem_we), .mem_addr(mem_addr),
                                .mem_wdata(mem_wdata), .mem_rdata(mem_rdata));
            sram_bank u_ram (.clk(clk), .re(mem_re), .we(mem_we), .addr(mem_addr),
                             .wdata(mem_wdata), .rdata(mem_rdata));
        end

        // Crossbar grid, decoder lane c,b to arbiter port b,c.
        for (c = 0; c < N_CPUS; c = c + 1) begin : g_link_c
            for (b = 0; b < N_BANKS; b = b + 1) begin : g_link_b
                assign g_bank[b].port_if[c].re    = g_cpu[c].lane_if[b].re;
                assign g_bank[b].port_if[c].we    = g_cpu[c].lane_if[b].we;
                assign g_bank[b].port_if[c].addr  = g_cpu[c].lane_if[b].addr;
                assign g_bank[b].port_if[c].wdata = g_cpu[c].lane_if[b].wdata;
                assign g_cpu[c].lane_if[b].ready  = g_bank[b].port_if[c].ready;
                assign g_cpu[c].lane_if[b].rdata  = g_bank[b].port_if[c].rdata;
            end
        end
    endgenerate

endmodule

// ==== tb/xbar_tb.sv ====
// Needs a simulator with concurrent assertions and timing; banks are filled before any checked read.
module xbar_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import xbar_pkg::*;

    // Stimulus needs about 600 cycles, the limit leaves a wide margin.
    localparam int TEST_CYCLES = 600;
    localparam int MAX_CYCLES  = TEST_CYCLES * 3 + 200;
    localparam logic [31:0] SEED = 32'h2289fbe2;

    logic                            clk;
    logic                            rst;
    logic [N_CPUS-1:0]               cpu_re;
    logic [N_CPUS-1:0][WES-1:0]      cpu_we;
    logic [N_CPUS-1:0][ALEN-1:2]     cpu_addr;
    logic [N_CPUS-1:0][DLEN-1:0]     cpu_wdata;
    logic [N_CPUS-1:0]               cpu_ready;
    logic [N_CPUS-1:0][DLEN-1:0]     cpu_rdata;

    // Request each CPU presented in the previous cycle.
    logic [N_CPUS-1:0]               pend_valid;
    logic [N_CPUS-1:0]               pend_re;
    logic [N_CPUS-1:0][WES-1:0]      pend_we;
    logic [N_CPUS-1:0][ALEN-1:2]     pend_addr;
    logic [N_CPUS-1:0][DLEN-1:0]     pend_wdata;
    logic [N_CPUS-1:0]               pend_mapped;
    logic [N_CPUS-1:0]               pend_bank;
    // Pending request already lost arbitration once.
    logic [N_CPUS-1:0]               lost_q;
    // Last CPU served per bank, CPU 1 after reset so CPU 0 goes first.
    logic [N_BANKS-1:0]              last_served;
    logic                            contended;
    logic                            exp_win;
    logic [N_CPUS-1:0][DLEN-1:0]     exp_rdata;
    // Byte model of both banks.
    logic [7:0]                      model [2**MAP_TOP_LSB];

    int rst_cycles = 0;
    int cycles = 0;
    int n_mismatch = 0;
    int n_other = 0;

    xbar_top DUT (
        .clk(clk), .rst(rst), .cpu_re(cpu_re), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Both CPUs hit the same mapped bank.
    assign contended = (&pend_valid) && (&pend_mapped) && (pend_bank[0] == pend_bank[1]);
    // Round-robin: whoever was not served last.
    assign exp_win   = ~last_served[pend_bank[0]];

    always_comb begin
        for (int c = 0; c < N_CPUS; c++) begin
            for (int i = 0; i < WES; i++) begin
                exp_rdata[c][8*i +: 8] = model[{pend_addr[c][BANK_SEL_LSB:2], 2'(i)}];
            end
        end
    end

    // Track requests, completions and the model.
    always @(posedge clk) begin
        if (rst) begin
            pend_valid  <= '0;
            lost_q      <= '0;
            last_served <= '1;
            rst_cycles  <= rst_cycles + 1;
        end else begin
            rst_cycles <= 0;
            for (int c = 0; c < N_CPUS; c++) begin
                if (pend_valid[c] && cpu_ready[c] && pend_mapped[c]) begin
                    for (int i = 0; i < WES; i++) begin
                        if (pend_we[c][i]) begin
                            model[{pend_addr[c][BANK_SEL_LSB:2], 2'(i)}] <=
                                pend_wdata[c][8*i +: 8];
                        end
                    end
                    last_served[pend_bank[c]] <= 1'(c);
                end
                pend_valid[c] <= cpu_re[c] || (|cpu_we[c]);
                pend_re[c]    <= cpu_re[c];
                pend_we[c]    <= cpu_we[c];
                pend_addr[c]  <= cpu_addr[c];
                pend_wdata[c] <= cpu_wdata[c];
                // Not ready means the same request is being held.
                lost_q[c]     <= pend_valid[c] && !cpu_ready[c];
            end
        end
    end

    genvar c;
    generate
        for (c = 0; c < N_CPUS; c = c + 1) begin : g_chk
            assign pend_mapped[c] = (pend_addr[c][ALEN-1:MAP_TOP_LSB] == '0);
            assign pend_bank[c]   = pend_addr[c][BANK_SEL_LSB];

            // Skip the first reset edge, sel_q is still unknown before it.
            reset_ready: assert property (@(posedge clk) (rst && rst_cycles > 0) |-> cpu_ready[c])
                else begin
                    n_other = n_other + 1;
                    $display("cpu %0d not ready during reset at %0t", c, $time);
                end
            idle_ready: assert property (@(posedge clk) disable iff (rst)
                !pend_valid[c] |-> cpu_ready[c])
                else begin
                    n_other = n_other + 1;
                    $display("cpu %0d not ready after an idle cycle at %0t", c, $time);
                end
            // Covers unmapped requests as well.
            single_cycle: assert property (@(posedge clk) disable iff (rst)
                (pend_valid[c] && !contended) |-> cpu_ready[c])
                else begin
                    n_other = n_other + 1;
                    $display("cpu %0d uncontested request took more than one cycle at %0t",
                             c, $time);
                end
            wait_bound: assert property (@(posedge clk) disable iff (rst)
                (pend_valid[c] && lost_q[c]) |-> cpu_ready[c])
                else begin
                    n_other = n_other + 1;
                    $display("cpu %0d waited more than two cycles at %0t", c, $time);
                end
            read_data: assert property (@(posedge clk) disable iff (rst)
                (pend_valid[c] && pend_re[c] && pend_mapped[c] && cpu_ready[c])
                |-> (cpu_rdata[c] == exp_rdata[c]))
                else begin
                    n_mismatch = n_mismatch + 1;
                    $display("mismatch at %0t: cpu_rdata[%0d] expected %08h actual %08h",
                             $time, c, $sampled(exp_rdata[c]), $sampled(cpu_rdata[c]));
                end
        end
    endgenerate

    one_ready: assert property (@(posedge clk) disable iff (rst)
        contended |-> (cpu_ready[0] != cpu_ready[1]))
        else begin
            n_other = n_other + 1;
            $display("both or neither CPU ready after contention at %0t", $time);
        end
    rr_winner: assert property (@(posedge clk) disable iff (rst) contended |-> cpu_ready[exp_win])
        else begin
            n_other = n_other + 1;
            $display("cpu %0d should have won the contended bank at %0t", $sampled(exp_win), $time);
        end

    // Pattern built from the full byte address.
    function automatic logic [DLEN-1:0] fill_word(input logic [ALEN-1:0] baddr);
        return {baddr ^ 16'h5a5a, ~baddr};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Drive one request and hold it until ready; returns in the ready cycle.
    task automatic access(input int c, input logic re, input logic [WES-1:0] we,
                          input logic [ALEN-1:2] addr, input logic [DLEN-1:0] wdata);
        cpu_re[c]    = re;
        cpu_we[c]    = we;
        cpu_addr[c]  = addr;
        cpu_wdata[c] = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_ready[c]);
    endtask

    task automatic go_idle(input int c);
        cpu_re[c] = 1'b0;
        cpu_we[c] = '0;
        wait_cycles(1);
    endtask

    // Back-to-back full writes over a whole bank.
    task automatic fill_bank(input int c, input int bank);
        logic [ALEN-1:2] wa;
        for (int w = 0; w < 2**BANK_AW; w++) begin
            wa = (ALEN-2)'(bank * (2**BANK_AW) + w);
            access(c, 1'b0, '1, wa, fill_word({wa, 2'b00}));
        end
        go_idle(c);
    endtask

    // Single write then read of the same word, alternating banks.
    task automatic write_read_back(input int c, input int n, input bit partial);
        logic [ALEN-1:2] wa;
        logic [WES-1:0]  we;
        for (int i = 0; i < n; i++) begin
            wa = (ALEN-2)'((i % N_BANKS) * (2**BANK_AW) + $urandom_range(0, 2**BANK_AW - 1));
            we = partial ? WES'($urandom_range(1, 2**WES - 2)) : '1;
            access(c, 1'b0, we, wa, $urandom);
            go_idle(c);
            access(c, 1'b1, '0, wa, '0);
            go_idle(c);
        end
    endtask

    // Random reads and writes streamed into one bank.
    task automatic stream(input int c, input int bank, input int n);
        logic [ALEN-1:2] wa;
        for (int i = 0; i < n; i++) begin
            wa = (ALEN-2)'(bank * (2**BANK_AW) + $urandom_range(0, 2**BANK_AW - 1));
            if ($urandom_range(0, 1) == 1) begin
                access(c, 1'b0, '1, wa, $urandom);
            end else begin
                access(c, 1'b1, '0, wa, '0);
            end
        end
        go_idle(c);
    endtask

    // Write above 2 KiB, then read the word it would alias to.
    task automatic unmapped_writes(input int c, input int n);
        logic [ALEN-1:2] wa;
        logic [ALEN-1:2] ua;
        for (int i = 0; i < n; i++) begin
            wa = (ALEN-2)'($urandom_range(0, 2**(MAP_TOP_LSB-2) - 1));
            ua = wa | ((ALEN-2)'($urandom_range(1, 31)) << (MAP_TOP_LSB - 2));
            access(c, 1'b0, '1, ua, $urandom);
            go_idle(c);
            access(c, 1'b1, '0, wa, '0);
            go_idle(c);
        end
    endtask

    task automatic report_result();
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            n_other = n_other + 1;
            $display("timeout after %0d cycles, stimulus did not finish", cycles);
            report_result();
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        cpu_re    = '0;
        cpu_we    = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        apply_reset();
        wait_cycles(2);
        // Different banks in the same cycles, leaves every word defined.
        fork
            fill_bank(0, 0);
            fill_bank(1, 1);
        join
        wait_cycles(2);
        write_read_back(0, 12, 1'b0);
        write_read_back(1, 12, 1'b0);
        write_read_back(0, 12, 1'b1);
        write_read_back(1, 12, 1'b1);
        // Fresh pointers, so the first contended grant goes to CPU 0.
        apply_reset();
        wait_cycles(1);
        fork
            stream(0, 0, 20);
            stream(1, 0, 20);
        join
        fork
            stream(0, 1, 20);
            stream(1, 1, 20);
        join
        unmapped_writes(0, 6);
        unmapped_writes(1, 6);
        wait_cycles(3);
        report_result();
        $finish;
    end

endmodule

// ==== src.f ====
hw/xbar_pkg.sv
hw/mem_bus_if.sv
hw/addr_decoder.sv
hw/bank_arbiter.sv
hw/resp_router.sv
hw/sram_bank.sv
hw/xbar_top.sv
tb/xbar_tb.sv
